// ==== list.f ====
align_pkg.sv
align_word_fifo.sv
align_instr_extract.sv
align_fetch_ctrl.sv
instr_align_buffer.sv
tb_instr_align_buffer.sv

// ==== Bender.yml ====
package:
  name: instr_align_buffer

sources:
  - align_pkg.sv
  - align_word_fifo.sv
  - align_instr_extract.sv
  - align_fetch_ctrl.sv
  - instr_align_buffer.sv
  - target: test
    files:
      - tb_instr_align_buffer.sv

// ==== tb_instr_align_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_instr_align_buffer;

  localparam int NUM_TESTS   = 6;
  localparam int MEM_WORDS   = 256;
  // Injection per table row
  localparam int MODE_NONE   = 0;
  localparam int MODE_BRANCH = 1;
  localparam int MODE_KILL   = 2;
  localparam int MODE_PERR   = 3;

  logic        clk;
  logic        rst_n;
  logic        instr_req;
  logic        pc_set;
  logic [31:0] branch_addr;
  logic        kill;
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;
  logic        resp_valid;
  logic [31:0] resp_rdata;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr_rdata;
  logic [31:0] instr_addr;
  logic        prefetch_busy;
  logic        protocol_err;

  // Stimulus table, one row per test
  string       t_name   [NUM_TESTS];
  logic [31:0] t_target [NUM_TESTS];
  int          t_count  [NUM_TESTS];
  int          t_pct    [NUM_TESTS];
  int          t_dmin   [NUM_TESTS];
  int          t_dmax   [NUM_TESTS];
  int          t_mode   [NUM_TESTS];

  // Instruction memory behind the prefetcher
  logic [31:0] mem [MEM_WORDS];

  // Prefetcher model, requests in flight with their due cycle
  logic [31:0] req_addr_q [$];
  int unsigned req_due_q  [$];
  logic [31:0] fetch_addr;
  int unsigned issued;
  int unsigned returned;

  // Reference walker
  logic [31:0] exp_addr;
  int          consumed;

  // Knobs for the next driven cycle
  logic        want_req;
  logic        want_branch;
  logic        want_kill;
  logic        want_perr;
  logic        expect_perr;
  logic [31:0] want_target;
  int unsigned ready_pct;
  int unsigned dly_min;
  int unsigned dly_max;

  int unsigned cycle_cnt;
  int unsigned timeout_limit = 0;
  int unsigned seed;
  int          err_count;
  int          pass_tests;
  int          fail_tests;
  int          total;

  instr_align_buffer i_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req),
    .pc_set_i            (pc_set),
    .branch_addr_i       (branch_addr),
    .kill_i              (kill),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_rdata_i        (resp_rdata),
    .instr_valid_o       (instr_valid),
    .instr_ready_i       (instr_ready),
    .instr_rdata_o       (instr_rdata),
    .instr_addr_o        (instr_addr),
    .prefetch_busy_o     (prefetch_busy),
    .protocol_err_o      (protocol_err)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Table and memory setup
  //////////////////////////////////////////////////////////////////////

  task automatic set_row(input int idx, input string name, input logic [31:0] target,
                         input int count, input int pct, input int dmin, input int dmax,
                         input int mode);
    t_name[idx]   = name;
    t_target[idx] = target;
    t_count[idx]  = count;
    t_pct[idx]    = pct;
    t_dmin[idx]   = dmin;
    t_dmax[idx]   = dmax;
    t_mode[idx]   = mode;
  endtask

  task automatic fill_table();
    //       name               target        n   rdy% dly   inject
    set_row(0, "aligned_full",  32'h0000_0000, 40, 100, 1, 1, MODE_NONE);
    set_row(1, "aligned_rand",  32'h0000_0040, 60, 60,  1, 4, MODE_NONE);
    set_row(2, "halfword_tgt",  32'h0000_00a2, 50, 70,  1, 3, MODE_NONE);
    set_row(3, "mid_branch",    32'h0000_0010, 60, 80,  2, 5, MODE_BRANCH);
    set_row(4, "kill_restart",  32'h0000_0120, 60, 75,  1, 4, MODE_KILL);
    set_row(5, "protocol_err",  32'h0000_0200, 20, 100, 1, 2, MODE_PERR);
  endtask

  // Roughly half the halfwords open a 32-bit instruction
  function automatic logic [15:0] biased_half();
    logic [15:0] hw;
    hw = $urandom;
    if (($urandom % 100) < 45) begin
      hw[1:0] = 2'b11;
    end else begin
      hw[1:0] = $urandom % 3;
    end
    return hw;
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {biased_half(), biased_half()};
    end
  endtask

  // Halfword at a byte address, memory wraps
  function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] word;
    word = mem[(addr >> 2) % MEM_WORDS];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("mismatch at %0d ns: %s expected 0x%h actual 0x%h", $time, sig, exp_val, act_val);
    err_count++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle: drive on the rising edge, observe on the falling
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    logic [31:0] rd_addr;
    @(posedge clk);
    instr_req   <= want_req;
    pc_set      <= want_branch;
    kill        <= want_kill;
    branch_addr <= want_target;
    fetch_ready <= ($urandom % 100) < ready_pct;
    // Consumer idle in the branch cycle
    instr_ready <= !want_branch && (($urandom % 100) < ready_pct);
    expect_perr = want_perr;
    resp_valid  <= 1'b0;
    if (want_perr) begin
      // Response with nothing requested
      resp_valid <= 1'b1;
      resp_rdata <= $urandom;
    end else if (req_due_q.size() != 0 && req_due_q[0] <= cycle_cnt + 1) begin
      rd_addr = req_addr_q.pop_front();
      req_due_q.delete(0);
      resp_valid <= 1'b1;
      resp_rdata <= mem[(rd_addr >> 2) % MEM_WORDS];
    end
  endtask

  task automatic observe_cycle();
    logic [15:0] lo;
    logic [31:0] exp_data;
    logic        comp;
    int unsigned dly;
    int unsigned in_flight;
    @(negedge clk);
    cycle_cnt++;
    in_flight = issued - returned;
    if (kill && instr_valid) begin
      $display("instr_valid_o high during kill_i at %0d ns", $time);
      err_count++;
    end
    if (protocol_err !== expect_perr) begin
      report_mismatch("protocol_err_o", {31'b0, expect_perr}, {31'b0, protocol_err});
    end
    // Request accounting against the model
    if (in_flight != 0 && !prefetch_busy) begin
      $display("prefetch_busy_o low with %0d requests in flight at %0d ns", in_flight, $time);
      err_count++;
    end
    if (in_flight >= align_pkg::MAX_OUTSTANDING && fetch_valid) begin
      $display("fetch_valid_o high with %0d requests in flight at %0d ns", in_flight, $time);
      err_count++;
    end
    // Branch flag follows the redirect
    if (fetch_branch !== pc_set) begin
      report_mismatch("fetch_branch_o", {31'b0, pc_set}, {31'b0, fetch_branch});
    end
    // Prefetcher restarts at the branch word
    if (fetch_branch) begin
      if (fetch_branch_addr !== {branch_addr[31:1], 1'b0}) begin
        report_mismatch("fetch_branch_addr_o", {branch_addr[31:1], 1'b0}, fetch_branch_addr);
      end
      fetch_addr = {fetch_branch_addr[31:2], 2'b00};
    end
    if (fetch_valid && fetch_ready) begin
      dly = dly_min + ($urandom % (dly_max - dly_min + 1));
      req_addr_q.push_back(fetch_addr);
      req_due_q.push_back(cycle_cnt + dly);
      fetch_addr = fetch_addr + 32'd4;
      issued++;
    end
    if (resp_valid && !expect_perr) begin
      returned++;
    end
    // Instruction transfer against the walker
    if (instr_valid && instr_ready && !pc_set) begin
      lo       = mem_half(exp_addr);
      comp     = lo[1:0] != align_pkg::UNCOMP_TAG;
      exp_data = {mem_half(exp_addr + 32'd2), lo};
      if (instr_addr !== exp_addr) begin
        report_mismatch("instr_addr_o", exp_addr, instr_addr);
      end
      if (comp && instr_rdata[15:0] !== lo) begin
        report_mismatch("instr_rdata_o", {16'h0, lo}, {16'h0, instr_rdata[15:0]});
      end else if (!comp && instr_rdata !== exp_data) begin
        report_mismatch("instr_rdata_o", exp_data, instr_rdata);
      end
      exp_addr = exp_addr + (comp ? 32'd2 : 32'd4);
      consumed++;
    end
    // New stream starts at the target
    if (pc_set) begin
      exp_addr = {branch_addr[31:1], 1'b0};
    end
  endtask

  task automatic step();
    drive_cycle();
    observe_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    int   errs_before;
    logic injected;
    errs_before = err_count;
    injected    = 1'b0;
    consumed    = 0;
    ready_pct   = t_pct[t];
    dly_min     = t_dmin[t];
    dly_max     = t_dmax[t];
    // Branch to the start of the stream
    want_req    = 1'b1;
    want_branch = 1'b1;
    want_target = t_target[t];
    step();
    want_branch = 1'b0;
    while (consumed < t_count[t]) begin
      if (!injected && consumed >= t_count[t] / 2 && t_mode[t] == MODE_BRANCH) begin
        // Redirect with responses still in flight, odd target loses bit 0
        injected    = 1'b1;
        want_branch = 1'b1;
        want_target = t_target[t] + 32'h107;
        step();
        want_branch = 1'b0;
      end else if (!injected && consumed >= t_count[t] / 2 && t_mode[t] == MODE_KILL) begin
        injected  = 1'b1;
        want_kill = 1'b1;
        step();
        want_kill   = 1'b0;
        want_branch = 1'b1;
        want_target = t_target[t] + 32'h84;
        step();
        want_branch = 1'b0;
      end else begin
        step();
      end
    end
    // Stop fetching and let the memory drain
    want_req  = 1'b0;
    ready_pct = 0;
    while (req_addr_q.size() != 0) begin
      step();
    end
    step();
    if (t_mode[t] == MODE_PERR) begin
      want_perr = 1'b1;
      step();
      want_perr = 1'b0;
      step();
    end
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %0d %s ok, %0d instructions", t, t_name[t], consumed);
    end else begin
      fail_tests++;
      $display("test %0d %s failed with %0d errors", t, t_name[t], err_count - errs_before);
    end
  endtask

  initial begin
    seed        = $urandom(94265);
    rst_n       = 1'b0;
    instr_req   = 1'b0;
    pc_set      = 1'b0;
    branch_addr = '0;
    kill        = 1'b0;
    fetch_ready = 1'b0;
    resp_valid  = 1'b0;
    resp_rdata  = '0;
    instr_ready = 1'b0;
    want_req    = 1'b0;
    want_branch = 1'b0;
    want_kill   = 1'b0;
    want_perr   = 1'b0;
    expect_perr = 1'b0;
    want_target = '0;
    fetch_addr  = '0;
    exp_addr    = '0;
    issued      = 0;
    returned    = 0;
    cycle_cnt   = 0;
    err_count   = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    total       = 0;
    fill_table();
    fill_memory();
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += t_count[t];
    end
    timeout_limit = total * 20;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    wait (timeout_limit != 0 && cycle_cnt >= timeout_limit);
    $display("timeout after %0d cycles, instruction stream stalled", cycle_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== instr_align_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_align_buffer (
  input  logic                       clk,
  input  logic                       rst_n,

  // Controller
  input  logic                       instr_req_i,
  input  logic                       pc_set_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,
  input  logic                       kill_i,

  // Prefetcher
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i,
  output logic                       fetch_branch_o,
  output logic [align_pkg::XLEN-1:0] fetch_branch_addr_o,

  // Memory responses, always accepted
  input  logic                       resp_valid_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,

  // Instruction output
  output logic                       instr_valid_o,
  input  logic                       instr_ready_i,
  output logic [align_pkg::XLEN-1:0] instr_rdata_o,
  output logic [align_pkg::XLEN-1:0] instr_addr_o,

  // Status
  output logic                       prefetch_busy_o,
  output logic                       protocol_err_o
);

  // Response after flush gating
  logic                       resp_accept;

  // Buffer read side
  logic [align_pkg::XLEN-1:0] head_word;
  logic                       head_valid;
  logic [align_pkg::XLEN-1:0] next_word;
  logic                       next_valid;
  logic                       word_pop;

  //////////////////////////////////////////////////////////////////////
  // Request control and counters
  //////////////////////////////////////////////////////////////////////

  align_fetch_ctrl i_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .pc_set_i            (pc_set_i),
    .kill_i              (kill_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_accept_o       (resp_accept),
    .instr_valid_i       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .prefetch_busy_o     (prefetch_busy_o),
    .protocol_err_o      (protocol_err_o)
  );

  // Word storage
  align_word_fifo i_word_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .word_pop_i    (word_pop),
    .head_word_o   (head_word),
    .head_valid_o  (head_valid),
    .next_word_o   (next_word),
    .next_valid_o  (next_valid)
  );

  // Halfword realignment and address sequence
  align_instr_extract i_extract (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .head_word_i   (head_word),
    .head_valid_i  (head_valid),
    .next_word_i   (next_word),
    .next_valid_i  (next_valid),
    .word_pop_o    (word_pop),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata_o),
    .instr_addr_o  (instr_addr_o)
  );

endmodule

`default_nettype wire

// ==== align_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_fetch_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,

  // Controller
  input  logic                       instr_req_i,
  input  logic                       pc_set_i,
  input  logic                       kill_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,

  // Prefetcher request side
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i,
  output logic                       fetch_branch_o,
  output logic [align_pkg::XLEN-1:0] fetch_branch_addr_o,

  // Memory responses
  input  logic                       resp_valid_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,
  output logic                       resp_accept_o,

  // Instruction handshake, observed for the pop term
  input  logic                       instr_valid_i,
  input  logic                       instr_ready_i,

  // Status
  output logic                       prefetch_busy_o,
  output logic                       protocol_err_o
);

  // Complete instructions held in the buffer
  logic [align_pkg::ALBUF_CNT_W-1:0] instr_cnt_q;
  logic [align_pkg::ALBUF_CNT_W-1:0] instr_cnt_n;
  logic [align_pkg::ALBUF_CNT_W-1:0] instr_cnt_avail;
  logic [align_pkg::ALBUF_CNT_W-1:0] n_incoming;
  logic [align_pkg::ALBUF_CNT_W-1:0] pop_dec;

  // Instruction consumed last cycle
  logic pop_q;

  // Requests in flight and responses still to drop
  logic [align_pkg::ALBUF_PTR_W-1:0] outstanding_q;
  logic [align_pkg::ALBUF_PTR_W-1:0] outstanding_n;
  logic [align_pkg::ALBUF_PTR_W-1:0] flush_q;
  logic [align_pkg::ALBUF_PTR_W-1:0] flush_n;
  logic [align_pkg::ALBUF_PTR_W-1:0] flush_branch;
  logic count_up;
  logic count_down;

  // Write side alignment
  align_pkg::wr_align_e wr_align_q;
  align_pkg::wr_align_e wr_align_n;

  logic lo_is_uncomp;
  logic hi_is_uncomp;

  //////////////////////////////////////////////////////////////////////
  // Fetch request gating
  //////////////////////////////////////////////////////////////////////

  assign pop_dec         = {{(align_pkg::ALBUF_CNT_W-1){1'b0}}, pop_q};
  assign instr_cnt_avail = instr_cnt_q - pop_dec;

  // Keep fetching until one instruction plus one request, or two instructions
  assign fetch_valid_o = instr_req_i &&
                         (outstanding_q < align_pkg::MAX_OUTSTANDING) &&
                         ((instr_cnt_avail == '0) ||
                          ((instr_cnt_avail == 1) && (outstanding_q == '0)) ||
                          pc_set_i);

  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[align_pkg::XLEN-1:1], 1'b0};

  // Drop responses belonging to the old stream
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  assign prefetch_busy_o = (outstanding_q != '0) || fetch_valid_o;
  // Response with no request to answer
  assign protocol_err_o  = resp_valid_i && (outstanding_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Outstanding and flush counters
  //////////////////////////////////////////////////////////////////////

  assign count_up   = fetch_valid_o && fetch_ready_i;
  assign count_down = resp_valid_i && (outstanding_q != '0);

  always_comb begin
    outstanding_n = outstanding_q;
    case ({count_up, count_down})
      2'b10:   outstanding_n = outstanding_q + 1'b1;
      2'b01:   outstanding_n = outstanding_q - 1'b1;
      default: outstanding_n = outstanding_q;
    endcase
  end

  // A response arriving with the branch is old, so one less to drop
  assign flush_branch = count_down ? outstanding_q - 1'b1 : outstanding_q;

  always_comb begin
    flush_n = flush_q;
    if (pc_set_i) begin
      flush_n = flush_branch;
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction count
  //////////////////////////////////////////////////////////////////////

  assign lo_is_uncomp = resp_rdata_i[1:0] == align_pkg::UNCOMP_TAG;
  assign hi_is_uncomp =
    resp_rdata_i[align_pkg::HALF_W+1:align_pkg::HALF_W] == align_pkg::UNCOMP_TAG;

  // Complete instructions carried by each accepted word
  always_comb begin
    wr_align_n = wr_align_q;
    n_incoming = '0;
    if (pc_set_i) begin
      wr_align_n = branch_addr_i[1] ? align_pkg::WR_BRANCH_HALF : align_pkg::WR_ALIGNED;
    end else if (resp_accept_o) begin
      case (wr_align_q)
        align_pkg::WR_ALIGNED: begin
          if (lo_is_uncomp) begin
            n_incoming = 1;
          end else if (hi_is_uncomp) begin
            // Upper half opens a split instruction
            n_incoming = 1;
            wr_align_n = align_pkg::WR_SPLIT;
          end else begin
            n_incoming = 2;
          end
        end
        align_pkg::WR_BRANCH_HALF: begin
          // Lower half is skipped
          if (hi_is_uncomp) begin
            n_incoming = 0;
            wr_align_n = align_pkg::WR_SPLIT;
          end else begin
            n_incoming = 1;
            wr_align_n = align_pkg::WR_ALIGNED;
          end
        end
        default: begin
          // Lower half closes the split one
          if (hi_is_uncomp) begin
            n_incoming = 1;
          end else begin
            n_incoming = 2;
            wr_align_n = align_pkg::WR_ALIGNED;
          end
        end
      endcase
    end
  end

  // Pop is subtracted one cycle late
  always_comb begin
    if (kill_i || pc_set_i) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + n_incoming - pop_dec;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_cnt_q   <= '0;
      outstanding_q <= '0;
      flush_q       <= '0;
      pop_q         <= 1'b0;
      wr_align_q    <= align_pkg::WR_ALIGNED;
    end else begin
      instr_cnt_q   <= instr_cnt_n;
      outstanding_q <= outstanding_n;
      flush_q       <= flush_n;
      // A transfer in the branch cycle belongs to the cleared count
      pop_q         <= instr_valid_i && instr_ready_i && !pc_set_i;
      wr_align_q    <= wr_align_n;
    end
  end

endmodule

`default_nettype wire

// ==== align_instr_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_instr_extract (
  input  logic                       clk,
  input  logic                       rst_n,

  // Stream control
  input  logic                       pc_set_i,
  input  logic                       kill_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,

  // Incoming word, used as bypass when the buffer runs short
  input  logic                       resp_accept_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,

  // Buffered words
  input  logic [align_pkg::XLEN-1:0] head_word_i,
  input  logic                       head_valid_i,
  input  logic [align_pkg::XLEN-1:0] next_word_i,
  input  logic                       next_valid_i,
  output logic                       word_pop_o,

  // Instruction side
  output logic                       instr_valid_o,
  input  logic                       instr_ready_i,
  output logic [align_pkg::XLEN-1:0] instr_rdata_o,
  output logic [align_pkg::XLEN-1:0] instr_addr_o
);

  // Address of the instruction on the output
  logic [align_pkg::XLEN-1:0] addr_q;
  logic [align_pkg::XLEN-1:0] addr_n;
  logic [align_pkg::XLEN-1:0] addr_incr;

  // Word holding the current address, and the halfword-shifted view
  logic [align_pkg::XLEN-1:0] instr_aligned;
  logic [align_pkg::XLEN-1:0] instr_unaligned;
  logic [align_pkg::HALF_W-1:0] upper_src;

  logic word_avail;
  logic pair_avail;
  logic aligned_is_comp;
  logic unaligned_is_comp;
  logic xfer;

  //////////////////////////////////////////////////////////////////////
  // Instruction selection
  //////////////////////////////////////////////////////////////////////

  // Head word, or the incoming word when the buffer is empty
  assign instr_aligned = head_valid_i ? head_word_i : resp_rdata_i;

  // Second halfword comes from the next entry or from the response
  assign upper_src       = next_valid_i ? next_word_i[align_pkg::HALF_W-1:0]
                                        : resp_rdata_i[align_pkg::HALF_W-1:0];
  assign instr_unaligned = {upper_src, instr_aligned[align_pkg::XLEN-1:align_pkg::HALF_W]};

  // Compressed unless the two low bits are all ones
  assign aligned_is_comp   = instr_aligned[1:0] != align_pkg::UNCOMP_TAG;
  assign unaligned_is_comp =
    instr_aligned[align_pkg::HALF_W+1:align_pkg::HALF_W] != align_pkg::UNCOMP_TAG;

  // At least one word present, counting the bypass
  assign word_avail = head_valid_i || resp_accept_i;
  // Two words present for a split 32-bit instruction
  assign pair_avail = next_valid_i || (head_valid_i && resp_accept_i);

  always_comb begin
    instr_valid_o = 1'b0;
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      // Upper halfword start
      instr_valid_o = word_avail && (unaligned_is_comp || pair_avail);
    end else begin
      instr_valid_o = word_avail;
    end
  end

  assign instr_rdata_o = addr_q[1] ? instr_unaligned : instr_aligned;
  assign instr_addr_o  = addr_q;

  //////////////////////////////////////////////////////////////////////
  // Address sequencing
  //////////////////////////////////////////////////////////////////////

  assign xfer      = instr_valid_o && instr_ready_i;
  assign addr_incr = {addr_q[align_pkg::XLEN-1:2], 2'b00} + 32'd4;

  // Head word is done once its upper halfword has been used
  assign word_pop_o = xfer && (addr_q[1] || !aligned_is_comp);

  always_comb begin
    addr_n = addr_q;
    if (addr_q[1]) begin
      // Compressed ends the word, otherwise we stop mid next word
      if (unaligned_is_comp) begin
        addr_n = {addr_incr[align_pkg::XLEN-1:2], 2'b00};
      end else begin
        addr_n = {addr_incr[align_pkg::XLEN-1:2], 2'b10};
      end
    end else begin
      if (aligned_is_comp) begin
        addr_n = {addr_q[align_pkg::XLEN-1:2], 2'b10};
      end else begin
        addr_n = addr_incr;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      // First instruction of the new stream sits at the target
      addr_q <= {branch_addr_i[align_pkg::XLEN-1:1], 1'b0};
    end else if (xfer) begin
      addr_q <= addr_n;
    end
  end

endmodule

`default_nettype wire

// ==== align_word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_word_fifo (
  input  logic                       clk,
  input  logic                       rst_n,

  // Stream control
  input  logic                       pc_set_i,
  input  logic                       kill_i,

  // Write side, one word per accepted response
  input  logic                       resp_accept_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,

  // Read side
  input  logic                       word_pop_i,
  output logic [align_pkg::XLEN-1:0] head_word_o,
  output logic                       head_valid_o,
  output logic [align_pkg::XLEN-1:0] next_word_o,
  output logic                       next_valid_o
);

  // Word storage, payload only
  logic [align_pkg::XLEN-1:0]        mem_q [align_pkg::ALBUF_DEPTH];

  // One valid bit per entry
  logic [align_pkg::ALBUF_DEPTH-1:0] valid_q;
  logic [align_pkg::ALBUF_DEPTH-1:0] valid_n;

  // Ring pointers and their wrapped successors
  logic [align_pkg::ALBUF_PTR_W-1:0] wptr_q;
  logic [align_pkg::ALBUF_PTR_W-1:0] rptr_q;
  logic [align_pkg::ALBUF_PTR_W-1:0] wptr_inc;
  logic [align_pkg::ALBUF_PTR_W-1:0] rptr_inc;

  //////////////////////////////////////////////////////////////////////
  // Pointer arithmetic
  //////////////////////////////////////////////////////////////////////

  // Wrap to entry zero after the last entry
  assign wptr_inc = (wptr_q == align_pkg::ALBUF_DEPTH - 1) ? '0 : wptr_q + 1'b1;
  assign rptr_inc = (rptr_q == align_pkg::ALBUF_DEPTH - 1) ? '0 : rptr_q + 1'b1;

  // Head is the oldest word, next is the one after it
  assign head_word_o  = mem_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_word_o  = mem_q[rptr_inc];
  assign next_valid_o = valid_q[rptr_inc];

  //////////////////////////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    valid_n = valid_q;
    // New word lands at the write pointer
    if (resp_accept_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    // Pop wins when the word is consumed straight from the bypass
    if (word_pop_i) begin
      valid_n[rptr_q] = 1'b0;
    end
    // Old stream is discarded, also blocks the write
    if (kill_i || pc_set_i) begin
      valid_n = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      // Empty buffer restarts at entry zero
      if (pc_set_i || kill_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (resp_accept_i) begin
          wptr_q <= wptr_inc;
        end
        if (word_pop_i) begin
          rptr_q <= rptr_inc;
        end
      end
    end
  end

  // Word payload
  always_ff @(posedge clk) begin
    if (resp_accept_i && !kill_i) begin
      mem_q[wptr_q] <= resp_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== align_pkg.sv ====
`default_nettype none

package align_pkg;

  //////////////////////////////////////////////////////////////////////
  // Buffer sizing
  //////////////////////////////////////////////////////////////////////

  // Word entries in the ring buffer
  localparam int unsigned ALBUF_DEPTH = 3;

  // Ring pointers and outstanding counter
  localparam int unsigned ALBUF_PTR_W = $clog2(ALBUF_DEPTH);

  // Up to two instructions per word, so one extra bit
  localparam int unsigned ALBUF_CNT_W = ALBUF_PTR_W + 1;

  // Word requests allowed in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN   = 32;
  localparam int unsigned HALF_W = 16;

  // Low bits of a 32-bit (uncompressed) instruction
  localparam logic [1:0] UNCOMP_TAG = 2'b11;

  // Write side alignment of the next incoming word
  typedef enum logic [1:0] {
    // Word starts with an instruction
    WR_ALIGNED,
    // Unaligned branch target, lower halfword is dropped
    WR_BRANCH_HALF,
    // Lower halfword finishes the instruction of the previous word
    WR_SPLIT
  } wr_align_e;

endpackage

`default_nettype wire
